/* Bender.yml */
package:
  name: mips_core

sources:
  - hw/mips_pkg.sv
  - hw/id_ex_if.sv
  - hw/instr_port.sv
  - hw/register_file.sv
  - hw/decode_stage.sv
  - hw/pc_unit.sv
  - hw/exec_stage.sv
  - hw/mips_core_top.sv
  - target: test
    files:
      - tests/tb_mips_core.sv

/* flist.f */
hw/mips_pkg.sv
hw/id_ex_if.sv
hw/instr_port.sv
hw/register_file.sv
hw/decode_stage.sv
hw/pc_unit.sv
hw/exec_stage.sv
hw/mips_core_top.sv
tests/tb_mips_core.sv

/* hw/decode_stage.sv */
`default_nettype none

module decode_stage (
   input  wire logic                i_clk,
   input  wire logic                i_rst,
   input  wire logic                i_issue,
   input  wire mips_pkg::word_t     i_instr,
   input  wire mips_pkg::word_t     i_pc,
   input  wire logic                i_wb_en,
   input  wire mips_pkg::reg_addr_t i_wb_addr,
   input  wire mips_pkg::word_t     i_wb_data,
   output logic                     o_redirect,
   output mips_pkg::word_t          o_target,
   id_ex_if.producer                id_ex
);

   mips_pkg::opcode_t   opcode;
   mips_pkg::funct_t    funct;
   mips_pkg::reg_addr_t rs_addr;
   mips_pkg::reg_addr_t rt_addr;
   mips_pkg::reg_addr_t rd_addr;
   mips_pkg::word_t     imm_sext;
   mips_pkg::word_t     imm_zext;
   mips_pkg::word_t     shamt_ext;
   mips_pkg::word_t     pc_plus4;
   mips_pkg::word_t     rs_val;
   mips_pkg::word_t     rt_val;

   // control outputs of the decoder
   mips_pkg::word_t     imm;
   mips_pkg::alu_op_t   alu_op;
   mips_pkg::a_sel_t    a_sel;
   mips_pkg::b_sel_t    b_sel;
   mips_pkg::reg_addr_t dest;
   logic                writes;
   logic                is_jump;
   logic                is_jreg;
   logic                is_beq;
   logic                is_bne;
   logic                rs_eq_rt;

   assign opcode    = i_instr[31:26];
   assign funct     = i_instr[5:0];
   assign rs_addr   = i_instr[25:21];
   assign rt_addr   = i_instr[20:16];
   assign rd_addr   = i_instr[15:11];
   assign imm_sext  = {{16{i_instr[15]}}, i_instr[15:0]};
   assign imm_zext  = {16'h0, i_instr[15:0]};
   assign shamt_ext = {27'h0, i_instr[10:6]};
   assign pc_plus4  = i_pc + 32'd4;

   register_file u_register_file (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_rs_addr (rs_addr),
      .i_rt_addr (rt_addr),
      .i_wr_addr (i_wb_addr),
      .i_wr_en   (i_wb_en),
      .i_wr_data (i_wb_data),
      .o_rs_val  (rs_val),
      .o_rt_val  (rt_val)
   );

   always_comb begin
      imm     = imm_sext;
      alu_op  = mips_pkg::ALU_NONE;
      a_sel   = mips_pkg::A_ZERO;
      b_sel   = mips_pkg::B_RT;
      dest    = rt_addr;
      writes  = 1'b0;  // unknown ops retire as nop
      is_jump = 1'b0;
      is_jreg = 1'b0;
      is_beq  = 1'b0;
      is_bne  = 1'b0;
      case (opcode)
         mips_pkg::OP_SPECIAL: begin
            imm    = shamt_ext;
            dest   = rd_addr;
            a_sel  = mips_pkg::A_RS;
            writes = 1'b1;
            case (funct)
               mips_pkg::FN_SLL: begin
                  alu_op = mips_pkg::ALU_SLL;
                  a_sel  = mips_pkg::A_SHAMT;
               end
               mips_pkg::FN_SRL: begin
                  alu_op = mips_pkg::ALU_SRL;
                  a_sel  = mips_pkg::A_SHAMT;
               end
               mips_pkg::FN_SRA: begin
                  alu_op = mips_pkg::ALU_SRA;
                  a_sel  = mips_pkg::A_SHAMT;
               end
               mips_pkg::FN_SLLV: alu_op = mips_pkg::ALU_SLL;  // amount from rs
               mips_pkg::FN_SRLV: alu_op = mips_pkg::ALU_SRL;
               mips_pkg::FN_SRAV: alu_op = mips_pkg::ALU_SRA;
               mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
               mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
               mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
               mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
               mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
               mips_pkg::FN_NOR:  alu_op = mips_pkg::ALU_NOR;
               mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
               mips_pkg::FN_JR: begin
                  is_jreg = 1'b1;
                  writes  = 1'b0;
               end
               mips_pkg::FN_JALR: begin
                  is_jreg = 1'b1;
                  alu_op  = mips_pkg::ALU_LINK;
                  a_sel   = mips_pkg::A_PC;
               end
               default: writes = 1'b0;
            endcase
         end
         mips_pkg::OP_J: is_jump = 1'b1;
         mips_pkg::OP_JAL: begin
            is_jump = 1'b1;
            alu_op  = mips_pkg::ALU_LINK;
            a_sel   = mips_pkg::A_PC;
            dest    = mips_pkg::RA_REG;
            writes  = 1'b1;
         end
         mips_pkg::OP_BEQ: is_beq = 1'b1;
         mips_pkg::OP_BNE: is_bne = 1'b1;
         mips_pkg::OP_ADDI, mips_pkg::OP_SLTI: begin
            alu_op = (opcode == mips_pkg::OP_ADDI) ? mips_pkg::ALU_ADD : mips_pkg::ALU_SLT;
            a_sel  = mips_pkg::A_RS;
            b_sel  = mips_pkg::B_IMM;
            writes = 1'b1;
         end
         mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI: begin
            imm    = imm_zext;
            alu_op = (opcode == mips_pkg::OP_ANDI) ? mips_pkg::ALU_AND :
                     (opcode == mips_pkg::OP_ORI)  ? mips_pkg::ALU_OR  : mips_pkg::ALU_XOR;
            a_sel  = mips_pkg::A_RS;
            b_sel  = mips_pkg::B_IMM;
            writes = 1'b1;
         end
         mips_pkg::OP_LUI: begin
            imm    = imm_zext;
            alu_op = mips_pkg::ALU_LUI;
            b_sel  = mips_pkg::B_IMM;
            writes = 1'b1;
         end
         default: ;
      endcase
   end

   // branch and jump resolution in the decode cycle
   assign rs_eq_rt   = (rs_val == rt_val);
   assign o_redirect = is_jump | is_jreg | (is_beq & rs_eq_rt) | (is_bne & ~rs_eq_rt);
   assign o_target   = is_jreg ? rs_val :
                       is_jump ? {4'h0, i_instr[25:0], 2'b00} :
                                 pc_plus4 + {imm_sext[29:0], 2'b00};

   always_ff @(posedge i_clk) begin
      if (i_rst)
         id_ex.valid <= 1'b0;
      else
         id_ex.valid <= i_issue;
   end

   always_ff @(posedge i_clk) begin
      if (i_issue) begin
         id_ex.pc     <= i_pc;
         id_ex.rs_val <= rs_val;
         id_ex.rt_val <= rt_val;
         id_ex.imm    <= imm;
         id_ex.alu_op <= alu_op;
         id_ex.a_sel  <= a_sel;
         id_ex.b_sel  <= b_sel;
         id_ex.dest   <= dest;
         id_ex.wr_en  <= writes && (dest != '0);  // r0 never written
      end
   end

endmodule

`default_nettype wire

/* hw/exec_stage.sv */
`default_nettype none

module exec_stage (
   input  wire logic           i_clk,
   input  wire logic           i_rst,
   id_ex_if.consumer           id_ex,
   output logic                o_retire,
   output logic                o_wb_en,
   output mips_pkg::reg_addr_t o_wb_addr,
   output mips_pkg::word_t     o_wb_data
);

   mips_pkg::word_t op_a;
   mips_pkg::word_t op_b;
   mips_pkg::word_t result;
   logic [4:0]      shamt;

   always_comb begin
      case (id_ex.a_sel)
         mips_pkg::A_RS:    op_a = id_ex.rs_val;
         mips_pkg::A_SHAMT: op_a = id_ex.imm;
         mips_pkg::A_PC:    op_a = id_ex.pc;
         default:           op_a = '0;
      endcase
   end

   assign op_b  = (id_ex.b_sel == mips_pkg::B_IMM) ? id_ex.imm : id_ex.rt_val;
   assign shamt = op_a[4:0];  // shamt or rs[4:0]

   always_comb begin
      case (id_ex.alu_op)
         mips_pkg::ALU_ADD:  result = op_a + op_b;
         mips_pkg::ALU_SUB:  result = op_a - op_b;
         mips_pkg::ALU_AND:  result = op_a & op_b;
         mips_pkg::ALU_OR:   result = op_a | op_b;
         mips_pkg::ALU_XOR:  result = op_a ^ op_b;
         mips_pkg::ALU_NOR:  result = ~(op_a | op_b);
         mips_pkg::ALU_SLT:  result = {31'h0, $signed(op_a) < $signed(op_b)};
         mips_pkg::ALU_SLL:  result = op_b << shamt;
         mips_pkg::ALU_SRL:  result = op_b >> shamt;
         mips_pkg::ALU_SRA:  result = $signed(op_b) >>> shamt;
         mips_pkg::ALU_LUI:  result = {op_b[15:0], 16'h0};
         mips_pkg::ALU_LINK: result = op_a + 32'd4;  // return address
         default:            result = '0;
      endcase
   end

   // ex/wb register
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_retire <= 1'b0;
         o_wb_en  <= 1'b0;
      end else begin
         o_retire <= id_ex.valid;
         o_wb_en  <= id_ex.valid & id_ex.wr_en;
      end
   end

   always_ff @(posedge i_clk) begin
      if (id_ex.valid) begin
         o_wb_addr <= id_ex.dest;
         o_wb_data <= result;
      end
   end

endmodule

`default_nettype wire

/* hw/id_ex_if.sv */
`default_nettype none

// decoded instruction handed from decode to execute
interface id_ex_if;
   logic               valid;
   mips_pkg::word_t    pc;
   mips_pkg::word_t    rs_val;
   mips_pkg::word_t    rt_val;
   mips_pkg::word_t    imm;     // already extended
   mips_pkg::alu_op_t  alu_op;
   mips_pkg::a_sel_t   a_sel;
   mips_pkg::b_sel_t   b_sel;
   mips_pkg::reg_addr_t dest;
   logic               wr_en;

   modport producer (output valid, pc, rs_val, rt_val, imm, alu_op, a_sel, b_sel, dest, wr_en);
   modport consumer (input valid, pc, rs_val, rt_val, imm, alu_op, a_sel, b_sel, dest, wr_en);
endinterface

`default_nettype wire

/* hw/instr_port.sv */
`default_nettype none

module instr_port (
   input  wire logic            i_clk,
   input  wire logic            i_rst,
   input  wire logic            i_req,
   input  wire mips_pkg::word_t i_instr,
   input  wire logic            i_retire,
   output logic                 o_ack,
   output logic                 o_issue,
   output mips_pkg::word_t      o_instr
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_BUSY,   // instruction in flight
      ST_DONE    // retired and holding ack
   } port_state_t;

   port_state_t state;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state   <= ST_IDLE;
         o_ack   <= 1'b0;
         o_issue <= 1'b0;
      end else begin
         o_issue <= 1'b0;  // single cycle pulse
         case (state)
            ST_IDLE: begin
               if (i_req) begin
                  o_issue <= 1'b1;
                  state   <= ST_BUSY;
               end
            end
            ST_BUSY: begin
               if (i_retire) begin
                  o_ack <= 1'b1;
                  state <= ST_DONE;
               end
            end
            ST_DONE: begin
               // agent must drop req before the next one
               if (!i_req) begin
                  o_ack <= 1'b0;
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == ST_IDLE && i_req)
         o_instr <= i_instr;  // word of the new request
   end

endmodule

`default_nettype wire

/* hw/mips_core_top.sv */
`default_nettype none

module mips_core_top (
   input  wire logic        i_clk,
   input  wire logic        i_rst,
   input  wire logic        i_req,
   input  wire logic [31:0] i_instr,
   output logic             o_ack,
   output logic [31:0]      o_pc,
   output logic             o_wb_en,
   output logic [4:0]       o_wb_addr,
   output logic [31:0]      o_wb_data
);

   logic                issue;
   logic                retire;
   logic                redirect;
   mips_pkg::word_t     instr_q;   // captured instruction
   mips_pkg::word_t     pc;
   mips_pkg::word_t     target;
   mips_pkg::reg_addr_t wb_addr;
   mips_pkg::word_t     wb_data;
   logic                wb_en;

   id_ex_if id_ex ();

   instr_port u_instr_port (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_req    (i_req),
      .i_instr  (i_instr),
      .i_retire (retire),
      .o_ack    (o_ack),
      .o_issue  (issue),
      .o_instr  (instr_q)
   );

   pc_unit u_pc_unit (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_issue    (issue),
      .i_redirect (redirect),
      .i_target   (target),
      .o_pc       (pc)
   );

   decode_stage u_decode_stage (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_issue    (issue),
      .i_instr    (instr_q),
      .i_pc       (pc),
      .i_wb_en    (wb_en),
      .i_wb_addr  (wb_addr),
      .i_wb_data  (wb_data),
      .o_redirect (redirect),
      .o_target   (target),
      .id_ex      (id_ex.producer)
   );

   exec_stage u_exec_stage (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .id_ex     (id_ex.consumer),
      .o_retire  (retire),
      .o_wb_en   (wb_en),
      .o_wb_addr (wb_addr),
      .o_wb_data (wb_data)
   );

   assign o_pc      = pc;
   assign o_wb_en   = wb_en;
   assign o_wb_addr = wb_addr;
   assign o_wb_data = wb_data;

endmodule

`default_nettype wire

/* hw/mips_pkg.sv */
`default_nettype none

package mips_pkg;

   typedef logic [31:0] word_t;     // data word and pc
   typedef logic [4:0]  reg_addr_t;
   typedef logic [5:0]  opcode_t;
   typedef logic [5:0]  funct_t;
   typedef logic [3:0]  alu_op_t;
   typedef logic [1:0]  a_sel_t;
   typedef logic        b_sel_t;

   // alu operations
   localparam alu_op_t ALU_ADD  = 4'd0;
   localparam alu_op_t ALU_SUB  = 4'd1;
   localparam alu_op_t ALU_AND  = 4'd2;
   localparam alu_op_t ALU_OR   = 4'd3;
   localparam alu_op_t ALU_XOR  = 4'd4;
   localparam alu_op_t ALU_NOR  = 4'd5;
   localparam alu_op_t ALU_SLT  = 4'd6;
   localparam alu_op_t ALU_SLL  = 4'd7;
   localparam alu_op_t ALU_SRL  = 4'd8;
   localparam alu_op_t ALU_SRA  = 4'd9;
   localparam alu_op_t ALU_LUI  = 4'd10;
   localparam alu_op_t ALU_LINK = 4'd11;  // a + 4 as return address
   localparam alu_op_t ALU_NONE = 4'd15;

   // operand a source
   localparam a_sel_t A_RS    = 2'd0;
   localparam a_sel_t A_SHAMT = 2'd1;
   localparam a_sel_t A_PC    = 2'd2;
   localparam a_sel_t A_ZERO  = 2'd3;

   // operand b source
   localparam b_sel_t B_RT  = 1'b0;
   localparam b_sel_t B_IMM = 1'b1;

   // primary opcodes
   localparam opcode_t OP_SPECIAL = 6'h00;
   localparam opcode_t OP_J       = 6'h02;
   localparam opcode_t OP_JAL     = 6'h03;
   localparam opcode_t OP_BEQ     = 6'h04;
   localparam opcode_t OP_BNE     = 6'h05;
   localparam opcode_t OP_ADDI    = 6'h08;
   localparam opcode_t OP_SLTI    = 6'h0a;
   localparam opcode_t OP_ANDI    = 6'h0c;
   localparam opcode_t OP_ORI     = 6'h0d;
   localparam opcode_t OP_XORI    = 6'h0e;
   localparam opcode_t OP_LUI     = 6'h0f;

   // special funct codes
   localparam funct_t FN_SLL  = 6'h00;
   localparam funct_t FN_SRL  = 6'h02;
   localparam funct_t FN_SRA  = 6'h03;
   localparam funct_t FN_SLLV = 6'h04;
   localparam funct_t FN_SRLV = 6'h06;
   localparam funct_t FN_SRAV = 6'h07;
   localparam funct_t FN_JR   = 6'h08;
   localparam funct_t FN_JALR = 6'h09;
   localparam funct_t FN_ADDU = 6'h21;
   localparam funct_t FN_SUBU = 6'h23;
   localparam funct_t FN_AND  = 6'h24;
   localparam funct_t FN_OR   = 6'h25;
   localparam funct_t FN_XOR  = 6'h26;
   localparam funct_t FN_NOR  = 6'h27;
   localparam funct_t FN_SLT  = 6'h2a;

   localparam reg_addr_t RA_REG = 5'd31;  // link register

endpackage

`default_nettype wire

/* hw/pc_unit.sv */
`default_nettype none

module pc_unit (
   input  wire logic            i_clk,
   input  wire logic            i_rst,
   input  wire logic            i_issue,
   input  wire logic            i_redirect,
   input  wire mips_pkg::word_t i_target,
   output mips_pkg::word_t      o_pc
);

   mips_pkg::word_t pc_next;

   // redirect only means something while the instruction is issued
   assign pc_next = i_redirect ? i_target : o_pc + 32'd4;

   always_ff @(posedge i_clk) begin
      if (i_rst)
         o_pc <= '0;
      else if (i_issue)
         o_pc <= pc_next;
   end

endmodule

`default_nettype wire

/* hw/register_file.sv */
`default_nettype none

module register_file (
   input  wire logic                i_clk,
   input  wire logic                i_rst,
   input  wire mips_pkg::reg_addr_t i_rs_addr,
   input  wire mips_pkg::reg_addr_t i_rt_addr,
   input  wire mips_pkg::reg_addr_t i_wr_addr,
   input  wire logic                i_wr_en,
   input  wire mips_pkg::word_t     i_wr_data,
   output mips_pkg::word_t          o_rs_val,
   output mips_pkg::word_t          o_rt_val
);

   mips_pkg::word_t regs [32];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < 32; i++)
            regs[i] <= '0;
      end else if (i_wr_en && i_wr_addr != '0) begin
         regs[i_wr_addr] <= i_wr_data;
      end
   end

   // r0 hardwired to zero
   assign o_rs_val = (i_rs_addr == '0) ? '0 : regs[i_rs_addr];
   assign o_rt_val = (i_rt_addr == '0) ? '0 : regs[i_rt_addr];

endmodule

`default_nettype wire

/* tests/tb_mips_core.sv */
`default_nettype none

module tb_mips_core;

   localparam int N_SEED     = 15;
   localparam int N_IMM      = 40;
   localparam int N_SPEC     = 60;
   localparam int N_DIRECTED = 15;
   localparam int N_TOTAL    = N_SEED + N_IMM + N_SPEC + N_DIRECTED;

   // addi slti andi ori xori lui
   localparam logic [35:0] IMM_OPS = {6'h0f, 6'h0e, 6'h0d, 6'h0c, 6'h0a, 6'h08};
   // sll srl sra sllv srlv srav addu subu and or xor nor slt
   localparam logic [77:0] SPEC_FNS = {6'h2a, 6'h27, 6'h26, 6'h25, 6'h24, 6'h23, 6'h21,
                                       6'h07, 6'h06, 6'h04, 6'h03, 6'h02, 6'h00};

   typedef struct packed {
      logic [31:0] pc;
      logic        en;
      logic [4:0]  addr;
      logic [31:0] data;
   } step_t;

   logic        i_clk;
   logic        i_rst;
   logic        i_req;
   logic [31:0] i_instr;
   logic        o_ack;
   logic [31:0] o_pc;
   logic        o_wb_en;
   logic [4:0]  o_wb_addr;
   logic [31:0] o_wb_data;

   logic [31:0] model_regs [32];
   logic [31:0] model_pc;
   logic [31:0] exp_pc;      // pc expected at the next ack
   logic [36:0] exp_wr_q [$];  // {addr, data}
   logic [36:0] exp_wr;
   logic [31:0] rng_state;
   logic        ack_prev = 1'b0;
   int          ack_count = 0;
   int          issued = 0;

   mips_core_top uut (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_req     (i_req),
      .i_instr   (i_instr),
      .o_ack     (o_ack),
      .o_pc      (o_pc),
      .o_wb_en   (o_wb_en),
      .o_wb_addr (o_wb_addr),
      .o_wb_data (o_wb_data)
   );

   initial begin
      i_clk = 1'b0;
      forever #5 i_clk = ~i_clk;
   end

   function automatic logic [31:0] lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
                                              input logic [4:0] rd, input logic [4:0] sh,
                                              input logic [5:0] fn);
      return {6'h00, rs, rt, rd, sh, fn};
   endfunction

   function automatic logic [31:0] jtype_word(input logic [5:0] op, input logic [25:0] idx);
      return {op, idx};
   endfunction

   // next pc and write-back of one instruction against the model state
   function automatic step_t reference_step(input logic [31:0] instr, input logic [31:0] pc);
      step_t       s;
      logic [31:0] rsv;
      logic [31:0] rtv;
      logic [31:0] sext;
      logic [31:0] zext;
      logic [4:0]  sh;
      rsv    = model_regs[instr[25:21]];
      rtv    = model_regs[instr[20:16]];
      sext   = {{16{instr[15]}}, instr[15:0]};
      zext   = {16'h0, instr[15:0]};
      sh     = instr[10:6];
      s.pc   = pc + 32'd4;
      s.en   = 1'b1;
      s.addr = instr[20:16];  // rt for i-type
      s.data = '0;
      case (instr[31:26])
         6'h00: begin
            s.addr = instr[15:11];
            case (instr[5:0])
               6'h00: s.data = rtv << sh;
               6'h02: s.data = rtv >> sh;
               6'h03: s.data = $signed(rtv) >>> sh;
               6'h04: s.data = rtv << rsv[4:0];
               6'h06: s.data = rtv >> rsv[4:0];
               6'h07: s.data = $signed(rtv) >>> rsv[4:0];
               6'h08: begin
                  s.en = 1'b0;  // jr
                  s.pc = rsv;
               end
               6'h09: begin
                  s.pc   = rsv;  // jalr
                  s.data = pc + 32'd4;
               end
               6'h21: s.data = rsv + rtv;
               6'h23: s.data = rsv - rtv;
               6'h24: s.data = rsv & rtv;
               6'h25: s.data = rsv | rtv;
               6'h26: s.data = rsv ^ rtv;
               6'h27: s.data = ~(rsv | rtv);
               6'h2a: s.data = ($signed(rsv) < $signed(rtv)) ? 32'd1 : 32'd0;
               default: s.en = 1'b0;
            endcase
         end
         6'h02: begin
            s.en = 1'b0;
            s.pc = {4'h0, instr[25:0], 2'b00};
         end
         6'h03: begin
            s.pc   = {4'h0, instr[25:0], 2'b00};
            s.addr = 5'd31;
            s.data = pc + 32'd4;
         end
         6'h04: begin
            s.en = 1'b0;
            if (rsv == rtv)
               s.pc = pc + 32'd4 + {sext[29:0], 2'b00};
         end
         6'h05: begin
            s.en = 1'b0;
            if (rsv != rtv)
               s.pc = pc + 32'd4 + {sext[29:0], 2'b00};
         end
         6'h08: s.data = rsv + sext;
         6'h0a: s.data = ($signed(rsv) < $signed(sext)) ? 32'd1 : 32'd0;
         6'h0c: s.data = rsv & zext;
         6'h0d: s.data = rsv | zext;
         6'h0e: s.data = rsv ^ zext;
         6'h0f: s.data = {instr[15:0], 16'h0};
         default: s.en = 1'b0;  // unknown opcode is a nop
      endcase
      if (s.addr == 5'd0)
         s.en = 1'b0;
      return s;
   endfunction

   task automatic stop_with_failure();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] want);
      if (got !== want) begin
         $display("mismatch %s: got 0x%h expected 0x%h", name, got, want);
         stop_with_failure();
      end
   endtask

   task automatic handshake(input logic [31:0] instr, input int hold);
      @(posedge i_clk);
      i_instr <= instr;
      i_req   <= 1'b1;
      do
         @(posedge i_clk);
      while (o_ack !== 1'b1);
      repeat (hold) begin
         @(posedge i_clk);
         if (o_ack !== 1'b1) begin
            $display("ack dropped while the request was still held");
            stop_with_failure();
         end
      end
      i_req <= 1'b0;
      do
         @(posedge i_clk);
      while (o_ack !== 1'b0);
   endtask

   task automatic run_instr(input logic [31:0] instr, input int hold);
      step_t s;
      s = reference_step(instr, model_pc);
      if (s.en) begin
         exp_wr_q.push_back({s.addr, s.data});
         model_regs[s.addr] = s.data;
      end
      model_pc = s.pc;
      exp_pc   = s.pc;
      issued++;
      handshake(instr, hold);
   endtask

   // write-back and ack monitor
   always @(posedge i_clk) begin
      if (!i_rst) begin
         if (o_wb_en === 1'b1) begin
            if (exp_wr_q.size() == 0) begin
               $display("write-back seen with no instruction expecting one");
               stop_with_failure();
            end else begin
               exp_wr = exp_wr_q.pop_front();
               compare_value("o_wb_addr", o_wb_addr, exp_wr[36:32]);
               compare_value("o_wb_data", o_wb_data, exp_wr[31:0]);
            end
         end
         if (o_ack === 1'b1 && !ack_prev) begin
            if (exp_wr_q.size() != 0) begin
               $display("ack raised before the expected write-back");
               stop_with_failure();
            end
            compare_value("o_pc", o_pc, exp_pc);
            ack_count++;
         end
         ack_prev = (o_ack === 1'b1);
      end
   end

   initial begin
      repeat (N_TOTAL * 60 + 10) @(posedge i_clk);
      $display("timeout: the handshake did not complete in time");
      stop_with_failure();
   end

   initial begin
      logic [31:0] rnd;
      logic [31:0] rnd2;
      int          k;
      i_rst     = 1'b1;
      i_req     = 1'b0;
      i_instr   = '0;
      rng_state = 32'd25;
      model_pc  = '0;
      exp_pc    = '0;
      for (int i = 0; i < 32; i++)
         model_regs[i] = '0;
      repeat (3) @(posedge i_clk);
      i_rst <= 1'b0;
      @(posedge i_clk);
      compare_value("o_ack", o_ack, 32'd0);
      compare_value("o_wb_en", o_wb_en, 32'd0);
      compare_value("o_pc", o_pc, 32'd0);

      for (int i = 1; i <= N_SEED; i++) begin
         rnd = lcg_next();
         run_instr(itype_word(6'h0d, 5'd0, i[4:0], rnd[31:16]), 0);  // ori ri, r0
      end
      for (int i = 0; i < N_IMM; i++) begin
         rnd  = lcg_next();
         rnd2 = lcg_next();
         k    = rnd[31:24] % 6;
         run_instr(itype_word(IMM_OPS[k*6 +: 6], {1'b0, rnd[23:20]}, {1'b0, rnd[19:16]},
                              rnd2[31:16]), 0);
      end
      for (int i = 0; i < N_SPEC; i++) begin
         rnd  = lcg_next();
         rnd2 = lcg_next();
         k    = rnd[31:24] % 13;
         run_instr(rtype_word({1'b0, rnd[23:20]}, {1'b0, rnd[19:16]}, {1'b0, rnd[15:12]},
                              rnd2[31:27], SPEC_FNS[k*6 +: 6]), 0);
      end

      run_instr(itype_word(6'h0d, 5'd0, 5'd20, 16'h0100), 0);    // r20 holds a target
      run_instr(rtype_word(5'd20, 5'd0, 5'd0, 5'd0, 6'h08), 0);  // jr r20
      run_instr(rtype_word(5'd20, 5'd0, 5'd21, 5'd0, 6'h09), 0); // jalr r21, r20
      run_instr(jtype_word(6'h03, 26'h0000040), 0);
      run_instr(jtype_word(6'h02, 26'h0000123), 0);
      run_instr(itype_word(6'h04, 5'd3, 5'd3, 16'h0010), 0);     // taken when equal
      run_instr(itype_word(6'h05, 5'd3, 5'd3, 16'h0010), 0);     // not taken when equal
      run_instr(itype_word(6'h04, 5'd0, 5'd20, 16'hfff0), 0);    // not taken when unequal
      run_instr(itype_word(6'h05, 5'd0, 5'd20, 16'hfff0), 0);    // taken backward when unequal
      run_instr(itype_word(6'h04, 5'd0, 5'd0, 16'hffff), 0);

      run_instr(itype_word(6'h08, 5'd1, 5'd0, 16'h0005), 0);     // addi into r0
      run_instr(rtype_word(5'd1, 5'd2, 5'd0, 5'd0, 6'h21), 0);
      run_instr(rtype_word(5'd0, 5'd0, 5'd6, 5'd0, 6'h21), 0);   // r0 still zero
      run_instr(itype_word(6'h3f, 5'd1, 5'd2, 16'h1234), 3);     // unknown opcode
      run_instr(itype_word(6'h0d, 5'd0, 5'd7, 16'hbeef), 2);

      repeat (4) @(posedge i_clk);  // room for a stray write-back
      if (ack_count != issued) begin
         $display("saw %0d acks for %0d instructions", ack_count, issued);
         stop_with_failure();
      end else begin
         $display("Simulation completed successfully");
         $finish;
      end
   end

endmodule

`default_nettype wire
